/* compile.f */
src/loader_pkg.sv
src/prg_parser.sv
src/crt_parser.sv
src/basic_ptr_init.sv
src/mem_write_port.sv
src/c64_loader_top.sv
sim/tb_clock.sv
sim/tb_loader.sv

/* Makefile */
# Verilator build and run for the file loader testbench

VERILATOR ?= verilator
TOP       ?= tb_loader
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* sim/tb_loader.sv */
// Testbench for the file loader
//   Table of PRG and CRT downloads, applied in a loop
//   Reference model for memory writes, bank headers and autorun
//   Random memory slot gaps and payload bytes from an LCG

module tb_loader;

	localparam logic [24:0] CART_BASE  = 25'h100000;
	localparam int          ALIGN_BITS = 13;
	localparam int          LIMIT      = 5000;      // Cycles per wait

	typedef struct {
		logic [7:0]  index;
		bit          autorun;
		logic [15:0] start;     // PRG load address
		int          len0;      // PRG payload or first CHIP data size
		int          len1;      // Second CHIP data size
		logic [15:0] id;
		logic [7:0]  exrom;
		logic [7:0]  game;
	} test_t;

	logic clk_sys, reset_n;
	logic dl_active_i, dl_wait_o, mem_slot_i, autorun_en_i, autorun_o, detach_i;
	logic bank_stb_o, cart_attached_o;
	logic [15:0] prg_end_o;
	loader_pkg::dl_index_u  dl_index_i;
	loader_pkg::dl_byte_t   dl_byte_i;
	loader_pkg::mem_wr_t    mem_o;
	loader_pkg::cart_info_t cart_o;
	loader_pkg::bank_hdr_t  bank_o;

	test_t       tests[4];
	logic [7:0]  file_q[$];
	logic [32:0] exp_wr[$], got_wr[$];      // {addr, data}
	logic [80:0] exp_bank[$], got_bank[$];
	logic [15:0] exp_end;
	logic [31:0] lcg_state = 32'd1190;
	int          errors, checks, test_err, autorun_cnt;
	logic        slot_prev;

	tb_clock #(.PERIOD(40), .RESET_CYCLES(3)) u_clock (.clk_o(clk_sys), .reset_n_o(reset_n));

	c64_loader_top #(.CART_BASE(CART_BASE), .BANK_ALIGN_BITS(ALIGN_BITS)) i_dut (
		.clk_sys(clk_sys), .reset_n(reset_n),
		.dl_active_i(dl_active_i), .dl_index_i(dl_index_i), .dl_byte_i(dl_byte_i),
		.dl_wait_o(dl_wait_o), .mem_slot_i(mem_slot_i), .mem_o(mem_o),
		.autorun_en_i(autorun_en_i), .autorun_o(autorun_o), .detach_i(detach_i),
		.cart_o(cart_o), .bank_o(bank_o), .bank_stb_o(bank_stb_o),
		.cart_attached_o(cart_attached_o), .prg_end_o(prg_end_o)
	);

	function automatic logic [7:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	// Next multiple of the bank size, or the address itself
	function automatic logic [24:0] align_up(logic [24:0] a);
		logic [24:0] bank;
		bank = 25'd1 << ALIGN_BITS;
		return ((a + bank - 25'd1) / bank) * bank;
	endfunction

	task automatic expect_true(bit ok, string msg);
		checks++;
		assert (ok) else begin
			$display("[ERROR] %0t %s", $time, msg);
			errors++;
			test_err++;
		end
	endtask

	// Waits until the host may strobe again
	task automatic wait_ready(string what);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (dl_wait_o && n < LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (dl_wait_o) begin
			$display("Timeout: dl_wait_o stayed high while waiting for %s", what);
			$display("Done: errors found");
			$finish;
		end
	endtask

	// ============================================================
	// Slot source and output monitor
	// ============================================================
	initial begin
		int gap;
		gap = 0;
		forever begin
			@(posedge clk_sys);
			if (gap == 0) begin
				mem_slot_i <= 1'b1;
				gap = int'(lcg_next() % 8'd4);
			end else begin
				mem_slot_i <= 1'b0;
				gap--;
			end
		end
	end

	always @(negedge clk_sys) begin
		if (reset_n) begin
			if (mem_o.we) begin
				expect_true(slot_prev, "write without a slot one cycle before");
				got_wr.push_back({mem_o.addr, mem_o.data});
			end
			if (autorun_o)
				autorun_cnt++;
			if (bank_stb_o)
				got_bank.push_back(bank_o);
		end
		slot_prev = mem_slot_i;
	end

	// ============================================================
	// Reference model
	// ============================================================
	task automatic build_prg(test_t t);
		logic [7:0]  d;
		logic [15:0] e;
		file_q.push_back(t.start[7:0]);
		file_q.push_back(t.start[15:8]);
		for (int i = 0; i < t.len0; i++) begin
			d = lcg_next();
			file_q.push_back(d);
			exp_wr.push_back({25'(t.start) + 25'(i), d});
		end
		e = t.start + 16'(t.len0);              // BASIC end pointer
		exp_end = e;
		exp_wr.push_back({25'h2B, 8'h01});
		exp_wr.push_back({25'h2C, 8'h08});
		for (int k = 0; k < 3; k++) begin
			exp_wr.push_back({25'h2D + 25'(2 * k), e[7:0]});
			exp_wr.push_back({25'h2E + 25'(2 * k), e[15:8]});
		end
		exp_wr.push_back({25'hAC, 8'h00});
		exp_wr.push_back({25'hAD, 8'h00});
		exp_wr.push_back({25'hAE, e[7:0]});
		exp_wr.push_back({25'hAF, e[15:8]});
	endtask

	task automatic build_crt(test_t t);
		logic [24:0] a;
		logic [31:0] plen;
		logic [15:0] n, load;
		logic [7:0]  d;
		logic [7:0]  typ;
		for (int o = 0; o < 64; o++) begin
			case (o)
				'h16: file_q.push_back(t.id[15:8]);
				'h17: file_q.push_back(t.id[7:0]);
				'h18: file_q.push_back(t.exrom);
				'h19: file_q.push_back(t.game);
				default: file_q.push_back(8'h00);
			endcase
		end
		a = CART_BASE;
		for (int pk = 0; pk < 2; pk++) begin
			n    = 16'(pk == 0 ? t.len0 : t.len1);
			plen = 32'(n) + 32'd16;
			load = pk == 0 ? 16'h8000 : 16'hA000;
			typ  = 8'(pk + 1);
			a    = align_up(a);
			file_q.push_back("C");
			file_q.push_back("H");
			file_q.push_back("I");
			file_q.push_back("P");
			for (int b = 3; b >= 0; b--)
				file_q.push_back(plen[8*b +: 8]);
			file_q.push_back(8'h00);
			file_q.push_back(typ);              // Bank type
			file_q.push_back(8'h00);
			file_q.push_back(8'(pk));
			file_q.push_back(load[15:8]);
			file_q.push_back(load[7:0]);
			file_q.push_back(n[15:8]);
			file_q.push_back(n[7:0]);
			exp_bank.push_back({typ, 16'(pk), load, n, a});
			for (int i = 0; i < int'(n); i++) begin
				d = lcg_next();
				file_q.push_back(d);
				exp_wr.push_back({a, d});
				a++;
			end
		end
	endtask

	// ============================================================
	// One table entry
	// ============================================================
	task automatic run_test(int idx);
		test_t t;
		bit    crt;
		t   = tests[idx];
		crt = t.index == 8'h05 || t.index == 8'hC0;
		test_err = 0;
		autorun_cnt = 0;
		file_q.delete();
		exp_wr.delete();
		exp_bank.delete();
		got_wr.delete();
		got_bank.delete();
		if (crt) build_crt(t);
		else build_prg(t);

		@(posedge clk_sys);
		dl_index_i.raw <= t.index;
		autorun_en_i   <= t.autorun;
		dl_active_i    <= 1'b1;
		foreach (file_q[i]) begin
			wait_ready("the next file byte");
			@(posedge clk_sys);
			dl_byte_i <= '{wr: 1'b1, addr: 25'(i), data: file_q[i]};
			@(posedge clk_sys);
			dl_byte_i.wr <= 1'b0;
		end
		wait_ready("the last file byte");
		@(posedge clk_sys);
		dl_active_i <= 1'b0;
		repeat (2) @(posedge clk_sys);
		wait_ready("the end of the download");
		repeat (4) @(negedge clk_sys);

		expect_true(got_wr.size() == exp_wr.size(), "write count differs");
		foreach (exp_wr[i])
			if (i < got_wr.size())
				expect_true(got_wr[i] == exp_wr[i], $sformatf("write %0d got %h expected %h",
				            i, got_wr[i], exp_wr[i]));
		expect_true(autorun_cnt == ((!crt && t.autorun) ? 1 : 0), "autorun pulse count");
		expect_true(got_bank.size() == exp_bank.size(), "bank strobe count differs");
		foreach (exp_bank[i])
			if (i < got_bank.size())
				expect_true(got_bank[i] == exp_bank[i], $sformatf("bank %0d header wrong", i));
		if (!crt)
			expect_true(prg_end_o == exp_end, $sformatf("prg_end_o got %h expected %h",
			            prg_end_o, exp_end));
		if (crt) begin
			expect_true(cart_o == {t.id, t.exrom, t.game}, "cartridge id, EXROM or GAME");
			expect_true(cart_attached_o, "cartridge not attached after download");
			@(posedge clk_sys);
			detach_i <= 1'b1;
			@(posedge clk_sys);
			detach_i <= 1'b0;
			@(negedge clk_sys);
			expect_true(!cart_attached_o, "cartridge still attached after detach");
		end
		$display("test %0d %s: %0d writes, %0d banks, %s", idx, crt ? "CRT" : "PRG",
		         got_wr.size(), got_bank.size(), test_err == 0 ? "ok" : "FAILED");
	endtask

	initial begin
		int n;
		dl_active_i  = 1'b0;
		dl_index_i   = '0;
		dl_byte_i    = '0;
		mem_slot_i   = 1'b0;
		autorun_en_i = 1'b0;
		detach_i     = 1'b0;
		errors = 0;
		checks = 0;
		tests[0] = '{8'h04, 1'b1, 16'h0801, 24, 0, 16'h0000, 8'h00, 8'h00};
		tests[1] = '{8'h04, 1'b0, 16'hC000, 7, 0, 16'h0000, 8'h00, 8'h00};
		tests[2] = '{8'h05, 1'b1, 16'h0000, 20, 9, 16'h0020, 8'h00, 8'h01};
		tests[3] = '{8'hC0, 1'b0, 16'h0000, 5, 0, 16'h0005, 8'h01, 8'h00};

		n = 0;
		while (!reset_n && n < LIMIT) begin
			@(negedge clk_sys);
			n++;
		end
		if (!reset_n) begin
			$display("Timeout: reset_n was never released");
			$display("Done: errors found");
			$finish;
		end else begin
			for (int i = 0; i < 4; i++)
				run_test(i);

			$display("tests 4, checks %0d, errors %0d", checks, errors);
			if (errors == 0)
				$display("Done: no errors");
			else
				$display("Done: errors found");
			$finish;
		end
	end

endmodule

/* sim/tb_clock.sv */
// Testbench clock and reset source
//   Free running clock, reset held low for a few cycles

module tb_clock #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic clk_o,
	output logic reset_n_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	initial begin
		reset_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		reset_n_o <= 1'b1;          // Released on a clock edge
	end

endmodule

/* src/c64_loader_top.sv */
// File loader top level
//   Download kind decode from the index byte
//   PRG and CRT parsers, BASIC pointer initialiser
//   Request select into the memory write port
//   Host wait, download end detect and cartridge attach flag

module c64_loader_top #(
	parameter logic [loader_pkg::ADDR_W-1:0] CART_BASE = loader_pkg::CART_BASE_DEF,
	parameter int BANK_ALIGN_BITS = loader_pkg::BANK_ALIGN_BITS_DEF
) (
	input  logic                   clk_sys,
	input  logic                   reset_n,
	// Host
	input  logic                   dl_active_i,
	input  loader_pkg::dl_index_u  dl_index_i,
	input  loader_pkg::dl_byte_t   dl_byte_i,
	output logic                   dl_wait_o,
	// Memory
	input  logic                   mem_slot_i,
	output loader_pkg::mem_wr_t    mem_o,
	// System
	input  logic                   autorun_en_i,
	output logic                   autorun_o,
	input  logic                   detach_i,
	output loader_pkg::cart_info_t cart_o,
	output loader_pkg::bank_hdr_t  bank_o,
	output logic                   bank_stb_o,
	output logic                   cart_attached_o,
	output logic [15:0]            prg_end_o
);

	logic is_prg, is_crt;
	logic active_d, dl_fall, dl_rise;
	logic ptr_busy, wr_pend;
	logic [loader_pkg::ADDR_W-1:0] cur_addr;
	loader_pkg::wr_req_t prg_req, crt_req, ptr_req, req_sel;

	assign is_prg = dl_index_i.part.sub == 2'd0 && dl_index_i.part.slot == loader_pkg::IDX_PRG_SLOT;
	assign is_crt = dl_index_i.raw == loader_pkg::IDX_CRT || dl_index_i.raw == loader_pkg::IDX_CRT_ALT;

	assign dl_fall = active_d & ~dl_active_i;
	assign dl_rise = ~active_d & dl_active_i;

	// Only one source talks at a time
	always_comb begin
		if (ptr_busy)    req_sel = ptr_req;
		else if (is_crt) req_sel = crt_req;
		else if (is_prg) req_sel = prg_req;
		else             req_sel = '0;
	end

	assign dl_wait_o = wr_pend | req_sel.valid | ptr_busy;  // Request in flight counts too

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			active_d        <= 1'b0;
			cart_attached_o <= 1'b0;
		end else begin
			active_d <= dl_active_i;
			if (is_crt && (dl_fall || dl_rise))
				cart_attached_o <= dl_fall;       // Dropped while a new image loads
			if (detach_i)
				cart_attached_o <= 1'b0;
		end
	end

	prg_parser u_prg (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.active_i   (dl_active_i & is_prg),
		.byte_i     (dl_byte_i),
		.req_o      (prg_req),
		.end_addr_o (prg_end_o)
	);

	crt_parser #(.CART_BASE(CART_BASE), .BANK_ALIGN_BITS(BANK_ALIGN_BITS)) u_crt (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.active_i   (dl_active_i & is_crt),
		.byte_i     (dl_byte_i),
		.cur_addr_i (cur_addr),
		.req_o      (crt_req),
		.cart_o     (cart_o),
		.bank_o     (bank_o),
		.bank_stb_o (bank_stb_o)
	);

	basic_ptr_init u_ptr (
		.clk_sys      (clk_sys),
		.reset_n      (reset_n),
		.start_i      (dl_fall & is_prg),
		.end_addr_i   (prg_end_o),
		.autorun_en_i (autorun_en_i),
		.pend_i       (wr_pend),
		.req_o        (ptr_req),
		.busy_o       (ptr_busy),
		.autorun_o    (autorun_o)
	);

	mem_write_port #(.BANK_ALIGN_BITS(BANK_ALIGN_BITS)) u_port (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.req_i      (req_sel),
		.slot_i     (mem_slot_i),
		.pend_o     (wr_pend),
		.cur_addr_o (cur_addr),
		.mem_o      (mem_o)
	);

endmodule

/* src/mem_write_port.sv */
// Memory write port
//   Current load address with set, align and advance
//   One pending write issued in the cycle after a free slot

module mem_write_port #(
	parameter int BANK_ALIGN_BITS = loader_pkg::BANK_ALIGN_BITS_DEF
) (
	input  logic                          clk_sys,
	input  logic                          reset_n,
	input  loader_pkg::wr_req_t           req_i,
	input  logic                          slot_i,
	output logic                          pend_o,
	output logic [loader_pkg::ADDR_W-1:0] cur_addr_o,
	output loader_pkg::mem_wr_t           mem_o
);

	localparam int AW = loader_pkg::ADDR_W;
	localparam logic [AW-1:0] ALIGN_MASK = {{(AW-BANK_ALIGN_BITS){1'b0}}, {BANK_ALIGN_BITS{1'b1}}};

	logic          data_req;
	logic [AW-1:0] tgt_addr;
	logic [AW-1:0] pend_addr;
	logic [7:0]    pend_data;

	assign data_req = req_i.valid && req_i.kind == loader_pkg::WR_DATA;
	assign tgt_addr = req_i.use_addr ? req_i.addr : cur_addr_o;

	// ============================================================
	// Address and pending state
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			pend_o     <= 1'b0;
			cur_addr_o <= '0;
			mem_o.we   <= 1'b0;
		end else begin
			mem_o.we <= 1'b0;
			if (slot_i && pend_o) begin
				mem_o.we   <= 1'b1;
				mem_o.addr <= pend_addr;
				mem_o.data <= pend_data;
				pend_o     <= 1'b0;
			end

			if (req_i.valid) begin
				case (req_i.kind)
					loader_pkg::WR_SET_ADDR: cur_addr_o <= req_i.addr;
					loader_pkg::WR_ALIGN: begin
						if ((cur_addr_o & ALIGN_MASK) != '0)
							cur_addr_o <= (cur_addr_o | ALIGN_MASK) + AW'(1);
					end
					loader_pkg::WR_DATA: begin
						pend_o     <= 1'b1;
						cur_addr_o <= tgt_addr + AW'(1);
					end
					default: ;
				endcase
			end
		end
	end

	// Pending byte and its address
	always_ff @(posedge clk_sys) begin
		if (data_req) begin
			pend_addr <= tgt_addr;
			pend_data <= req_i.data;
		end
	end

	// Host wait and the pointer scan must keep data requests off a busy port
	a_no_overrun: assert property (@(posedge clk_sys) disable iff (!reset_n)
		data_req |-> !pend_o);

endmodule

/* src/basic_ptr_init.sv */
// BASIC pointer initialiser
//   Scans zero page after a PRG download
//   Writes TXT, VAR, ARY, STR, SAVE_START and LOAD_END pointers
//   Pulses autorun when done

module basic_ptr_init (
	input  logic                clk_sys,
	input  logic                reset_n,
	input  logic                start_i,
	input  logic [15:0]         end_addr_i,
	input  logic                autorun_en_i,
	input  logic                pend_i,
	output loader_pkg::wr_req_t req_o,
	output logic                busy_o,
	output logic                autorun_o
);

	logic [8:0] scan_addr;      // Bit 8 marks the end of zero page
	logic       is_ptr;
	logic [7:0] ptr_data;
	logic       port_free;

	// Port can take a write once our last request has landed as pending
	assign port_free = !pend_i && !req_o.valid;

	always_comb begin
		is_ptr   = 1'b1;
		ptr_data = 8'h00;
		case (scan_addr[7:0])
			8'h2B: ptr_data = 8'h01;                          // TXT, as after reset
			8'h2C: ptr_data = 8'h08;
			8'hAC, 8'hAD: ptr_data = 8'h00;                   // SAVE_START
			8'h2D, 8'h2F, 8'h31, 8'hAE: ptr_data = end_addr_i[7:0];
			8'h2E, 8'h30, 8'h32, 8'hAF: ptr_data = end_addr_i[15:8];
			default: is_ptr = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			req_o     <= '0;
			busy_o    <= 1'b0;
			autorun_o <= 1'b0;
			scan_addr <= '0;
		end else begin
			req_o.valid <= 1'b0;
			autorun_o   <= 1'b0;
			if (start_i) begin
				busy_o    <= 1'b1;
				scan_addr <= '0;
			end else if (busy_o) begin
				if (scan_addr[8]) begin
					// Finish only once the last pointer byte is out
					if (port_free) begin
						busy_o    <= 1'b0;
						autorun_o <= autorun_en_i;
					end
				end else if (is_ptr) begin
					if (port_free) begin
						req_o <= '{
							valid:    1'b1,
							kind:     loader_pkg::WR_DATA,
							use_addr: 1'b1,
							addr:     loader_pkg::ADDR_W'(scan_addr[7:0]),
							data:     ptr_data
						};
						scan_addr <= scan_addr + 9'd1;
					end
				end else begin
					scan_addr <= scan_addr + 9'd1;    // Not a pointer, skip
				end
			end
		end
	end

endmodule

/* src/crt_parser.sv */
// CRT cartridge image parser
//   File header fields (id, EXROM, GAME)
//   CHIP packet header decode with bank strobe
//   Bank data alignment and data write requests

module crt_parser #(
	parameter logic [loader_pkg::ADDR_W-1:0] CART_BASE = loader_pkg::CART_BASE_DEF,
	parameter int BANK_ALIGN_BITS = loader_pkg::BANK_ALIGN_BITS_DEF
) (
	input  logic                         clk_sys,
	input  logic                         reset_n,
	input  logic                         active_i,
	input  loader_pkg::dl_byte_t         byte_i,
	input  logic [loader_pkg::ADDR_W-1:0] cur_addr_i,
	output loader_pkg::wr_req_t          req_o,
	output loader_pkg::cart_info_t       cart_o,
	output loader_pkg::bank_hdr_t        bank_o,
	output logic                         bank_stb_o
);

	logic        take;
	logic [3:0]  hdr_cnt;       // Position inside the CHIP header, 0 when idle
	logic [31:0] blk_len;       // Data bytes left in the packet

	// Header fields collected before the strobe
	logic [7:0]  type_q;
	logic [15:0] num_q;
	logic [15:0] laddr_q;
	logic [7:0]  size_hi_q;

	assign take = active_i & byte_i.wr;

	// ============================================================
	// Packet sequencing and requests
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			req_o      <= '0;
			hdr_cnt    <= '0;
			blk_len    <= '0;
			bank_stb_o <= 1'b0;
		end else begin
			req_o.valid <= 1'b0;
			bank_stb_o  <= 1'b0;
			if (take) begin
				if (byte_i.addr == '0) begin
					req_o <= '{valid: 1'b1, kind: loader_pkg::WR_SET_ADDR,
					           use_addr: 1'b0, addr: CART_BASE, data: 8'h00};
					hdr_cnt <= '0;
					blk_len <= '0;
				end else if (byte_i.addr >= loader_pkg::ADDR_W'(8'h40)) begin
					if (blk_len == '0 && hdr_cnt == '0) begin
						// First byte of a CHIP packet
						hdr_cnt <= 4'd1;
						req_o <= '{valid: 1'b1, kind: loader_pkg::WR_ALIGN,
						           use_addr: 1'b0, addr: '0, data: 8'h00};
					end else if (hdr_cnt != '0) begin
						hdr_cnt <= hdr_cnt + 4'd1;        // Wraps to 0 after byte 15
						case (hdr_cnt)
							4'd4: blk_len[31:24] <= byte_i.data;
							4'd5: blk_len[23:16] <= byte_i.data;
							4'd6: blk_len[15:8]  <= byte_i.data;
							4'd7: blk_len[7:0]   <= byte_i.data;
							4'd8: blk_len        <= blk_len - 32'd16;  // Packet length covers header
							4'd15: bank_stb_o    <= 1'b1;
							default: ;
						endcase
					end else begin
						blk_len <= blk_len - 32'd1;
						req_o <= '{valid: 1'b1, kind: loader_pkg::WR_DATA,
						           use_addr: 1'b0, addr: '0, data: byte_i.data};
					end
				end
			end
		end
	end

	// ============================================================
	// Header fields
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (take) begin
			case (byte_i.addr)
				loader_pkg::ADDR_W'(8'h16): cart_o.id[15:8] <= byte_i.data;
				loader_pkg::ADDR_W'(8'h17): cart_o.id[7:0]  <= byte_i.data;
				loader_pkg::ADDR_W'(8'h18): cart_o.exrom    <= byte_i.data;
				loader_pkg::ADDR_W'(8'h19): cart_o.game     <= byte_i.data;
				default: ;
			endcase

			if (byte_i.addr >= loader_pkg::ADDR_W'(8'h40) && hdr_cnt != '0) begin
				case (hdr_cnt)
					4'd9:  type_q         <= byte_i.data;
					4'd10: num_q[15:8]    <= byte_i.data;
					4'd11: num_q[7:0]     <= byte_i.data;
					4'd12: laddr_q[15:8]  <= byte_i.data;
					4'd13: laddr_q[7:0]   <= byte_i.data;
					4'd14: size_hi_q      <= byte_i.data;
					4'd15: begin
						// Whole header published at once
						bank_o <= '{bank_type: type_q, bank_num: num_q, load_addr: laddr_q,
						            size: {size_hi_q, byte_i.data}, ram_addr: cur_addr_i};
					end
					default: ;
				endcase
			end
		end
	end

	// Strobe is a single pulse per packet
	a_bank_stb_single: assert property (@(posedge clk_sys) disable iff (!reset_n)
		bank_stb_o |=> !bank_stb_o);

	// The write port must have aligned the bank start before the header ends
	a_bank_aligned: assert property (@(posedge clk_sys) disable iff (!reset_n)
		bank_stb_o |-> bank_o.ram_addr[BANK_ALIGN_BITS-1:0] == '0);

endmodule

/* src/prg_parser.sv */
// PRG program parser
//   First two file bytes give the load address
//   Later bytes become data writes at consecutive addresses
//   Tracks the end address for the BASIC pointers

module prg_parser (
	input  logic                 clk_sys,
	input  logic                 reset_n,
	input  logic                 active_i,
	input  loader_pkg::dl_byte_t byte_i,
	output loader_pkg::wr_req_t  req_o,
	output logic [15:0]          end_addr_o
);

	localparam int PAD_W = loader_pkg::ADDR_W - 16;

	logic take;

	assign take = active_i & byte_i.wr;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			req_o      <= '0;
			end_addr_o <= '0;
		end else begin
			req_o.valid <= 1'b0;                  // Single cycle request
			if (take) begin
				if (byte_i.addr == '0) begin
					// Load address low byte
					end_addr_o[7:0] <= byte_i.data;
				end else if (byte_i.addr == loader_pkg::ADDR_W'(1)) begin
					// Load address high byte, start address is now known
					end_addr_o[15:8] <= byte_i.data;
					req_o <= '{
						valid:    1'b1,
						kind:     loader_pkg::WR_SET_ADDR,
						use_addr: 1'b0,
						addr:     {{PAD_W{1'b0}}, byte_i.data, end_addr_o[7:0]},
						data:     8'h00
					};
				end else begin
					end_addr_o <= end_addr_o + 16'd1;     // Wraps at 64 KB
					req_o <= '{
						valid:    1'b1,
						kind:     loader_pkg::WR_DATA,
						use_addr: 1'b0,
						addr:     '0,
						data:     byte_i.data
					};
				end
			end
		end
	end

endmodule

/* src/loader_pkg.sv */
// Shared definitions for the file loader
//   Address width, cartridge defaults and download index values
//   Download index union (whole byte or sub-type/slot pair)
//   Write request, host byte, memory write and cartridge records

package loader_pkg;

	// ============================================================
	// Constants
	// ============================================================
	localparam int ADDR_W = 25;

	localparam logic [ADDR_W-1:0] CART_BASE_DEF = 25'h100000;
	localparam int BANK_ALIGN_BITS_DEF = 13;        // 8 KB banks

	localparam logic [5:0] IDX_PRG_SLOT = 6'd4;
	localparam logic [7:0] IDX_CRT      = 8'h05;
	localparam logic [7:0] IDX_CRT_ALT  = 8'hC0;

	// ============================================================
	// Download index
	// ============================================================
	typedef struct packed {
		logic [1:0] sub;    // File sub-type
		logic [5:0] slot;   // Menu slot
	} dl_index_s;

	typedef union packed {
		logic [7:0] raw;
		dl_index_s  part;
	} dl_index_u;

	// ============================================================
	// Write requests and bus records
	// ============================================================
	typedef enum logic [1:0] {
		WR_SET_ADDR = 2'd0,     // Load address, no write
		WR_ALIGN    = 2'd1,     // Round up to next bank boundary
		WR_DATA     = 2'd2      // One byte, address advances
	} wr_kind_e;

	typedef struct packed {
		logic              valid;
		wr_kind_e          kind;
		logic              use_addr;  // Write at addr instead of current address
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} wr_req_t;

	typedef struct packed {
		logic              wr;
		logic [ADDR_W-1:0] addr;      // Offset within the file
		logic [7:0]        data;
	} dl_byte_t;

	typedef struct packed {
		logic [15:0] id;
		logic [7:0]  exrom;
		logic [7:0]  game;
	} cart_info_t;

	typedef struct packed {
		logic [7:0]        bank_type;
		logic [15:0]       bank_num;
		logic [15:0]       load_addr;
		logic [15:0]       size;
		logic [ADDR_W-1:0] ram_addr;  // Where the bank data starts in memory
	} bank_hdr_t;

	typedef struct packed {
		logic              we;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        data;
	} mem_wr_t;

endpackage
